// ==== rtl/mesh_route_settings.svh ====
`ifndef MESH_ROUTE_SETTINGS_SVH
`define MESH_ROUTE_SETTINGS_SVH

// mesh dimensions
`define MESH_NX 4
`define MESH_NY 4

// coordinate field widths, follow the grid size
`define MESH_XW ($clog2(`MESH_NX))
`define MESH_YW ($clog2(`MESH_NY))

// a mesh router always has five ports
`define MESH_PORTS 5

// 1: route computed in the network interface, 0: inside the router
`define ODD_EVEN_IN_NI 1

`endif

// ==== rtl/mesh_route_pkg.sv ====
`default_nettype none

`include "mesh_route_settings.svh"

package mesh_route_pkg;

    // router address, also used for the destination
    typedef struct packed {
        logic [`MESH_XW-1:0] x;
        logic [`MESH_YW-1:0] y;
    } mesh_coord_t;

    // bit positions inside a port mask
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1, // x increasing
        NORTH = 3'd2, // y decreasing
        WEST  = 3'd3,
        SOUTH = 3'd4  // y increasing
    } mesh_port_e;

    typedef logic [`MESH_PORTS-1:0] port_mask_t;

    // 6 and 7 reserved, no port allowed
    typedef enum logic [2:0] {
        XY             = 3'd0,
        WEST_FIRST     = 3'd1,
        NORTH_LAST     = 3'd2,
        NEGATIVE_FIRST = 3'd3,
        ODD_EVEN       = 3'd4,
        DUATO          = 3'd5
    } route_alg_e;

    typedef struct packed {
        logic x_plus;
        logic x_min;
        logic y_plus;
        logic y_min;
        logic same_x;
        logic same_y;
    } dir_flags_t;

    // compact code used by the adaptive port selection
    typedef struct packed {
        logic x_plus;
        logic y_min;
        logic use_x; // east or west allowed
        logic use_y; // north or south allowed
    } dest_code_t;

    typedef struct packed {
        port_mask_t mask;
        dest_code_t code;
    } route_result_t;

endpackage

`default_nettype wire

// ==== rtl/mesh_dir.sv ====
`default_nettype none

// direction of the destination as seen from the current router
module mesh_dir (
    input  mesh_route_pkg::mesh_coord_t cur,
    input  mesh_route_pkg::mesh_coord_t dst,
    output mesh_route_pkg::dir_flags_t  flags
);

    // x grows toward east
    always_comb begin
        flags.x_plus = (dst.x > cur.x);
        flags.x_min  = (dst.x < cur.x);
        flags.same_x = (dst.x == cur.x);
    end

    // y grows toward south, so y_min means north-bound
    always_comb begin
        flags.y_plus = (dst.y > cur.y);
        flags.y_min  = (dst.y < cur.y);
        flags.same_y = (dst.y == cur.y);
    end

endmodule

`default_nettype wire

// ==== rtl/turn_model_route.sv ====
`default_nettype none

// allowed output ports for xy, the turn models and duato
module turn_model_route (
    input  mesh_route_pkg::route_alg_e alg,
    input  mesh_route_pkg::dir_flags_t flags,
    output mesh_route_pkg::port_mask_t mask
);

    import mesh_route_pkg::*;

    port_mask_t productive; // every port that brings the flit closer
    port_mask_t x_only;     // productive ports on the x axis
    logic       diagonal;

    always_comb begin
        productive        = '0;
        productive[LOCAL] = flags.same_x && flags.same_y;
        productive[EAST]  = flags.x_plus;
        productive[WEST]  = flags.x_min;
        productive[NORTH] = flags.y_min;
        productive[SOUTH] = flags.y_plus;
    end

    always_comb begin
        x_only       = '0;
        x_only[EAST] = flags.x_plus;
        x_only[WEST] = flags.x_min;
    end

    // straight-line moves have a single productive port anyway
    assign diagonal = !flags.same_x && !flags.same_y;

    always_comb begin
        mask = '0;
        case (alg)
            XY: begin
                // x dimension is resolved first
                mask = diagonal ? x_only : productive;
            end
            WEST_FIRST: begin
                // no turn into west, so all west hops come first
                if (diagonal && flags.x_min) begin
                    mask       = '0;
                    mask[WEST] = 1'b1;
                end else begin
                    mask = productive;
                end
            end
            NORTH_LAST: begin
                if (diagonal && flags.y_min) begin
                    mask = x_only; // north only once x is done
                end else begin
                    mask = productive;
                end
            end
            NEGATIVE_FIRST: begin
                // west and north are the negative directions
                if (diagonal && flags.x_min && flags.y_min) begin
                    mask       = '0;
                    mask[WEST] = 1'b1;
                end else if (diagonal && flags.x_plus && flags.y_plus) begin
                    mask        = '0;
                    mask[SOUTH] = 1'b1; // no east to south turn
                end else begin
                    mask = productive;
                end
            end
            DUATO: begin
                mask = productive; // fully adaptive at mask level
            end
            default: begin
                mask = '0; // odd-even is handled elsewhere, 6 and 7 reserved
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/odd_even_route.sv ====
`default_nettype none

`include "mesh_route_settings.svh"

// odd-even turn model, restrictions depend on column parity
module odd_even_route (
    input  mesh_route_pkg::mesh_coord_t cur,
    input  mesh_route_pkg::mesh_coord_t dst,
    output mesh_route_pkg::port_mask_t  mask
);

    import mesh_route_pkg::*;

    localparam bit IN_NI = (`ODD_EVEN_IN_NI != 0);

    logic signed [`MESH_XW:0] x_off; // dst minus cur, one sign bit
    logic signed [`MESH_YW:0] y_off;
    logic                     cur_odd;
    logic                     dst_odd;
    port_mask_t               y_port; // productive port on the y axis

    assign x_off   = $signed({1'b0, dst.x}) - $signed({1'b0, cur.x});
    assign y_off   = $signed({1'b0, dst.y}) - $signed({1'b0, cur.y});
    assign cur_odd = cur.x[0];
    assign dst_odd = dst.x[0];

    always_comb begin
        y_port = '0;
        if (y_off < 0) begin
            y_port[NORTH] = 1'b1;
        end else if (y_off > 0) begin
            y_port[SOUTH] = 1'b1;
        end
    end

    always_comb begin
        mask = '0;
        if (x_off == 0 && y_off == 0) begin
            mask[LOCAL] = 1'b1;
        end else if (x_off == 0) begin
            mask = y_port; // same column
        end else if (y_off == 0) begin
            // same row
            if (x_off < 0) begin
                mask[WEST] = 1'b1;
            end else begin
                mask[EAST] = 1'b1;
            end
        end else if (x_off > 0) begin
            // east-bound
            if (cur_odd || IN_NI) begin
                mask = mask | y_port;
            end
            // one hop from an even column would force an east to y turn there
            if (dst_odd || x_off != 1) begin
                mask[EAST] = 1'b1;
            end
        end else begin
            // west-bound
            mask[WEST] = 1'b1;
            if (!cur_odd) begin
                mask = mask | y_port; // turns out of west only in even columns
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mesh_route_unit.sv ====
`default_nettype none

// route computation stage, one cycle from head strobe to result
module mesh_route_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          head_valid,
    input  mesh_route_pkg::mesh_coord_t   cur,
    input  mesh_route_pkg::mesh_coord_t   dst,
    input  mesh_route_pkg::route_alg_e    alg,
    output logic                          route_valid,
    output mesh_route_pkg::route_result_t result
);

    import mesh_route_pkg::*;

    dir_flags_t flags;
    port_mask_t tm_mask; // turn models, xy and duato
    port_mask_t oe_mask;
    port_mask_t sel_mask;
    dest_code_t code;

    mesh_dir u_mesh_dir (
        .cur   (cur),
        .dst   (dst),
        .flags (flags)
    );

    turn_model_route u_turn_model_route (
        .alg   (alg),
        .flags (flags),
        .mask  (tm_mask)
    );

    odd_even_route u_odd_even_route (
        .cur  (cur),
        .dst  (dst),
        .mask (oe_mask)
    );

    assign sel_mask = (alg == ODD_EVEN) ? oe_mask : tm_mask;

    // destination code for the adaptive port selection
    always_comb begin
        code.x_plus = flags.x_plus;
        code.y_min  = flags.y_min;
        code.use_x  = sel_mask[EAST] | sel_mask[WEST];
        code.use_y  = sel_mask[NORTH] | sel_mask[SOUTH];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            route_valid <= 1'b0;
            result      <= '0;
        end else begin
            route_valid <= head_valid; // one pulse per strobe
            if (head_valid) begin
                result.mask <= sel_mask;
                result.code <= code;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`default_nettype none

// testbench clock and power-on reset
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // release away from the rising edge
    end

endmodule

`default_nettype wire

// ==== test/tb_mesh_route.sv ====
`default_nettype none

`include "mesh_route_settings.svh"

module tb_mesh_route;

    timeunit 1ns;
    timeprecision 100ps;

    import mesh_route_pkg::*;

    localparam int MAX_VEC = 64;

    logic          clk;
    logic          rst_n;
    logic          head_valid;
    mesh_coord_t   cur;
    mesh_coord_t   dst;
    route_alg_e    alg;
    logic          route_valid;
    route_result_t result;

    // vectors loaded from the data file
    logic [2:0]  vec_alg [MAX_VEC];
    mesh_coord_t vec_cur [MAX_VEC];
    mesh_coord_t vec_dst [MAX_VEC];
    port_mask_t  vec_mask [MAX_VEC];
    dest_code_t  vec_code [MAX_VEC];

    int num_vec     = 0;
    int errors      = 0;
    int cycle_count = 0;
    int max_cycles  = 20;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mesh_route_unit u_mesh_route_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .head_valid  (head_valid),
        .cur         (cur),
        .dst         (dst),
        .alg         (alg),
        .route_valid (route_valid),
        .result      (result)
    );

    task automatic load_vectors();
        int                fd;
        int                n;
        int                f_alg, f_cx, f_cy, f_dx, f_dy, f_mask, f_code;
        logic [8*120-1:0]  line;
        fd = $fopen("test/route_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open test/route_testdata.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = '0;
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h %h %h",
                        f_alg, f_cx, f_cy, f_dx, f_dy, f_mask, f_code);
            if (n == 7 && num_vec < MAX_VEC) begin // comment lines give no match
                vec_alg[num_vec]   = f_alg[2:0];
                vec_cur[num_vec].x = f_cx[`MESH_XW-1:0];
                vec_cur[num_vec].y = f_cy[`MESH_YW-1:0];
                vec_dst[num_vec].x = f_dx[`MESH_XW-1:0];
                vec_dst[num_vec].y = f_dy[`MESH_YW-1:0];
                vec_mask[num_vec]  = f_mask[`MESH_PORTS-1:0];
                vec_code[num_vec]  = f_code[3:0];
                num_vec++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_vector(input int idx);
        head_valid = 1'b1;
        alg        = route_alg_e'(vec_alg[idx]);
        cur        = vec_cur[idx];
        dst        = vec_dst[idx];
    endtask

    // inputs move while idle, the result must not
    task automatic drive_idle();
        head_valid = 1'b0;
        alg        = DUATO;
        cur        = '0;
        dst        = '1;
    endtask

    task automatic check_result(input int idx);
        if (route_valid !== 1'b1) begin
            $display("CHECK FAILED at %0t: route_valid expected 1, got %b (vector %0d)",
                     $time, route_valid, idx);
            errors++;
        end
        if (result.mask !== vec_mask[idx]) begin
            $display("CHECK FAILED at %0t: result.mask expected %h, got %h (vector %0d)",
                     $time, vec_mask[idx], result.mask, idx);
            errors++;
        end
        if (result.code !== vec_code[idx]) begin
            $display("CHECK FAILED at %0t: result.code expected %h, got %h (vector %0d)",
                     $time, vec_code[idx], result.code, idx);
            errors++;
        end
    endtask

    task automatic check_quiet(input route_result_t held);
        if (route_valid !== 1'b0) begin
            $display("CHECK FAILED at %0t: route_valid expected 0, got %b",
                     $time, route_valid);
            errors++;
        end
        if (result !== held) begin
            $display("CHECK FAILED at %0t: result expected %h, got %h",
                     $time, held, result);
            errors++;
        end
    endtask

    // run limit grows with the number of vectors
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        head_valid = 1'b0;
        alg        = XY;
        cur        = '0;
        dst        = '0;
        load_vectors();
        max_cycles = 20 + 4 * num_vec;
        if (num_vec == 0) begin
            $display("no test vectors were loaded");
            errors++;
        end

        // reset values, during and after reset
        @(negedge clk);
        check_quiet('0);
        while (rst_n !== 1'b1) @(negedge clk);
        repeat (2) @(negedge clk);
        check_quiet('0);

        // one strobe at a time, result held while idle
        for (int i = 0; i < num_vec; i++) begin
            drive_vector(i);
            @(negedge clk);
            drive_idle();
            check_result(i);
            @(negedge clk);
            check_quiet({vec_mask[i], vec_code[i]});
        end

        // back to back strobes, each answered on the next cycle
        for (int i = 0; i < num_vec; i++) begin
            drive_vector(i);
            @(negedge clk);
            check_result(i);
        end
        drive_idle();
        @(negedge clk);
        if (num_vec > 0) begin
            check_quiet({vec_mask[num_vec-1], vec_code[num_vec-1]});
        end

        $display("vectors: %0d, errors: %0d", num_vec, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+rtl
rtl/mesh_route_pkg.sv
rtl/mesh_dir.sv
rtl/turn_model_route.sv
rtl/odd_even_route.sv
rtl/mesh_route_unit.sv
test/tb_clock_gen.sv
test/tb_mesh_route.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_mesh_route -o sim_mesh_route &&
    out=$(./obj_dir/sim_mesh_route) &&
    printf '%s\n' "$out" &&
    printf '%s\n' "$out" | grep -q "STATUS: PASS" &&
    echo "run_sim: simulation passed" ||
    { echo "run_sim: simulation failed"; exit 1; }

// ==== test/route_testdata.txt ====
// alg cur_x cur_y dst_x dst_y mask code, all hex
// alg 0 xy, 1 west-first, 2 north-last, 3 negative-first, 4 odd-even, 5 duato
0 1 1 1 1 01 0
0 0 0 3 2 02 a
0 2 3 2 0 04 5
0 3 1 0 2 08 2
1 3 3 1 0 08 6
1 0 3 2 1 06 f
1 0 0 3 3 12 b
1 2 2 0 2 08 2
2 3 3 0 0 08 6
2 3 0 1 2 18 3
2 0 3 3 1 02 e
2 1 0 2 3 12 b
3 2 2 0 0 08 6
3 2 0 0 3 18 3
3 0 2 3 0 06 f
3 1 1 3 3 10 9
3 0 1 0 3 10 1
4 0 0 2 2 12 b
4 0 3 1 0 06 f
4 1 0 2 3 10 9  offset of one to an even column
4 1 2 3 0 06 f
4 2 1 0 3 18 3  west from an even column
4 3 2 0 0 08 6  west from an odd column
4 2 2 2 2 01 0
4 3 1 3 0 04 5
5 0 0 3 3 12 b
5 3 3 0 0 0c 7
5 1 3 2 0 06 f
5 2 0 0 1 18 3
6 0 0 1 1 00 8  reserved algorithm
